/* logic/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    localparam wordT RESET_PC = 32'hbfc00000;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
    } aluOpT;

    typedef enum logic [2:0] {
        memNone, memLoadWord, memLoadByte, memLoadByteU, memStoreWord, memStoreByte
    } memOpT;

    typedef enum logic [1:0] {
        fwdRegFile, fwdFromMem, fwdFromWb
    } fwdSelT;

    typedef struct packed {
        logic   valid;     // low for a bubble
        aluOpT  aluOp;
        logic   useImm;    // operand b from immediate
        logic   regWrite;
        regIdxT destIdx;
        memOpT  memOp;
        logic   isBranch;
        logic   branchNe;  // bne when set, beq otherwise
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } fdT;

    typedef struct packed {
        wordT       pc;
        wordT       rsVal;
        wordT       rtVal;
        regIdxT     rsIdx;
        regIdxT     rtIdx;
        wordT       imm;
        logic [4:0] shamt;
        ctrlT       ctrl;
    } decExT;

    typedef struct packed {
        wordT   pc;
        wordT   aluOut;    // also the data address
        wordT   storeVal;
        regIdxT destIdx;
        logic   regWrite;
        memOpT  memOp;
        logic   valid;
    } exMemT;

    typedef struct packed {
        regIdxT destIdx;
        wordT   result;
        logic   regWrite;
    } memWbT;

    typedef struct packed {
        logic   valid;
        wordT   pc;
        logic   regWen;
        regIdxT regNum;
        wordT   regData;
    } wbDebugT;

endpackage

`default_nettype wire

/* logic/pipeReg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeReg import mipsPkg::*; #(
    parameter type payloadT = wordT
) (
    input  wire          clk,
    input  wire          rstN_i,
    input  wire          stall_i,
    input  wire          flush_i,
    input  wire payloadT d_i,
    output payloadT      q_o
);

    // an all-zero payload is a bubble in every stage
    always_ff @(posedge clk) begin
        if (!rstN_i || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* logic/fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import mipsPkg::*; #(
    parameter wordT resetPc = RESET_PC
) (
    input  wire       clk,
    input  wire       rstN_i,
    input  wire       stall_i,
    input  wire       branchTaken_i,
    input  wire wordT branchTarget_i,
    output wordT      pc_o,
    output wordT      instAddr_o,
    output logic      instEn_o
);

    wordT pcReg;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pcReg <= resetPc;
        end else if (!stall_i) begin
            // target replaces the fall-through after the delay slot
            pcReg <= branchTaken_i ? branchTarget_i : pcReg + 32'd4;
        end
    end

    assign pc_o       = pcReg;
    assign instAddr_o = pcReg;
    assign instEn_o   = ~stall_i;  // no new fetch while frozen

    pcAligned: assert property (@(posedge clk) disable iff (!rstN_i)
        pcReg[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pcReg);

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import mipsPkg::*; (
    input  wire       valid_i,
    input  wire wordT instr_i,
    output ctrlT      ctrl_o,
    output wordT      imm_o,
    output logic [4:0] shamt_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdxT     rtIdx;
    regIdxT     rdIdx;

    assign opcode  = instr_i[31:26];
    assign funct   = instr_i[5:0];
    assign rtIdx   = instr_i[20:16];
    assign rdIdx   = instr_i[15:11];
    assign shamt_o = instr_i[10:6];

    always_comb begin
        ctrl_o       = '0;
        ctrl_o.valid = valid_i;
        imm_o        = {{16{instr_i[15]}}, instr_i[15:0]};  // sign extended by default
        case (opcode)
            opSpecial: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIdx  = rdIdx;
                case (funct)
                    fnSll:   ctrl_o.aluOp = aluSll;
                    fnAddu:  ctrl_o.aluOp = aluAdd;
                    fnSubu:  ctrl_o.aluOp = aluSub;
                    fnAnd:   ctrl_o.aluOp = aluAnd;
                    fnOr:    ctrl_o.aluOp = aluOr;
                    fnXor:   ctrl_o.aluOp = aluXor;
                    fnSlt:   ctrl_o.aluOp = aluSlt;
                    default: ctrl_o = '0;  // unknown funct
                endcase
            end
            opBeq, opBne: begin
                ctrl_o.isBranch = 1'b1;
                ctrl_o.branchNe = (opcode == opBne);
            end
            opAddiu, opAndi, opOri, opLui: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIdx  = rtIdx;
                case (opcode)
                    opAndi:  ctrl_o.aluOp = aluAnd;
                    opOri:   ctrl_o.aluOp = aluOr;
                    opLui:   ctrl_o.aluOp = aluLui;
                    default: ctrl_o.aluOp = aluAdd;
                endcase
                if (opcode == opAndi || opcode == opOri) begin
                    imm_o = {16'h0000, instr_i[15:0]};  // logical ops zero extend
                end
            end
            opLw, opLb, opLbu: begin
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIdx  = rtIdx;
                ctrl_o.memOp    = (opcode == opLw) ? memLoadWord :
                                  (opcode == opLb) ? memLoadByte : memLoadByteU;
            end
            opSw, opSb: begin
                ctrl_o.useImm = 1'b1;
                ctrl_o.memOp  = (opcode == opSw) ? memStoreWord : memStoreByte;
            end
            default: ctrl_o = '0;
        endcase
        if (!valid_i) begin
            ctrl_o = '0;  // flushed slot stays a bubble
        end
    end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire         clk,
    input  wire         rstN_i,
    input  wire         we_i,
    input  wire regIdxT waddr_i,
    input  wire wordT   wdata_i,
    input  wire regIdxT raddrA_i,
    input  wire regIdxT raddrB_i,
    output wordT        rdataA_o,
    output wordT        rdataB_o
);

    wordT regs [32];
    logic wrActive;

    assign wrActive = rstN_i && we_i && (waddr_i != '0);  // $0 is never stored

    always_ff @(posedge clk) begin
        if (wrActive) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic wordT readPort(regIdxT idx);
        if (idx == '0) return '0;
        if (wrActive && idx == waddr_i) return wdata_i;  // writeback bypass
        return regs[idx];
    endfunction

    assign rdataA_o = readPort(raddrA_i);
    assign rdataB_o = readPort(raddrB_i);

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire decExT  de_i,
    input  wire fwdSelT fwdA_i,
    input  wire fwdSelT fwdB_i,
    input  wire wordT   memResult_i,
    input  wire wordT   wbResult_i,
    output exMemT       exOut_o,
    output logic        branchTaken_o,
    output wordT        branchTarget_o
);

    wordT rsFwd;
    wordT rtFwd;
    wordT opB;
    wordT aluOut;

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal);
        case (sel)
            fwdFromMem: return memResult_i;
            fwdFromWb:  return wbResult_i;
            default:    return regVal;
        endcase
    endfunction

    assign rsFwd = fwdMux(fwdA_i, de_i.rsVal);
    assign rtFwd = fwdMux(fwdB_i, de_i.rtVal);  // also the store data
    assign opB   = de_i.ctrl.useImm ? de_i.imm : rtFwd;

    always_comb begin
        case (de_i.ctrl.aluOp)
            aluAdd:  aluOut = rsFwd + opB;
            aluSub:  aluOut = rsFwd - opB;
            aluAnd:  aluOut = rsFwd & opB;
            aluOr:   aluOut = rsFwd | opB;
            aluXor:  aluOut = rsFwd ^ opB;
            aluSlt:  aluOut = {31'b0, $signed(rsFwd) < $signed(opB)};
            aluSll:  aluOut = opB << de_i.shamt;
            aluLui:  aluOut = {opB[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    // resolved here, fetch runs sequentially until then
    assign branchTaken_o  = de_i.ctrl.isBranch & ((rsFwd == rtFwd) ^ de_i.ctrl.branchNe);
    assign branchTarget_o = de_i.pc + 32'd4 + {de_i.imm[29:0], 2'b00};

    assign exOut_o = '{
        pc:       de_i.pc,
        aluOut:   aluOut,
        storeVal: rtFwd,
        destIdx:  de_i.ctrl.destIdx,
        regWrite: de_i.ctrl.regWrite,
        memOp:    de_i.ctrl.memOp,
        valid:    de_i.ctrl.valid
    };

endmodule

`default_nettype wire

/* logic/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  wire         clk,
    input  wire         rstN_i,
    input  wire regIdxT exRsIdx_i,
    input  wire regIdxT exRtIdx_i,
    input  wire regIdxT memDest_i,
    input  wire         memRegWrite_i,
    input  wire regIdxT wbDest_i,
    input  wire         wbRegWrite_i,
    input  wire         branchTaken_i,
    input  wire         dataStall_i,
    output logic        stall_o,
    output logic        flushFd_o,
    output fwdSelT      fwdA_o,
    output fwdSelT      fwdB_o
);

    // younger producer in memory wins over writeback
    function automatic fwdSelT fwdPick(regIdxT src);
        if (src == '0) return fwdRegFile;
        if (memRegWrite_i && memDest_i == src) return fwdFromMem;
        if (wbRegWrite_i && wbDest_i == src) return fwdFromWb;
        return fwdRegFile;
    endfunction

    assign fwdA_o    = fwdPick(exRsIdx_i);
    assign fwdB_o    = fwdPick(exRtIdx_i);
    assign stall_o   = dataStall_i;                   // whole pipe freezes
    assign flushFd_o = branchTaken_i & ~dataStall_i;  // kill slot after delay slot

    noZeroFwd: assert property (@(posedge clk) disable iff (!rstN_i)
        (memDest_i == '0) |-> (fwdA_o != fwdFromMem))
        else $error("register 0 forwarded from memory stage");

endmodule

`default_nettype wire

/* logic/memAccess.sv */
`timescale 1ns/10ps
`default_nettype none

module memAccess import mipsPkg::*; (
    input  wire        clk,
    input  wire        rstN_i,
    input  wire exMemT ex_i,
    input  wire wordT  memRdata_i,
    input  wire        dataStall_i,
    output logic       memEn_o,
    output wordT       memAddr_o,
    output logic [3:0] memWen_o,
    output wordT       memWdata_o,
    output wordT       result_o,
    output wbDebugT    wbDebug_o
);

    logic       isStore;
    logic       isLoad;
    logic [1:0] lane;
    logic [7:0] loadByte;
    wordT       loadVal;

    assign isStore  = (ex_i.memOp == memStoreWord) || (ex_i.memOp == memStoreByte);
    assign isLoad   = (ex_i.memOp != memNone) && !isStore;
    assign lane     = ex_i.aluOut[1:0];
    assign loadByte = memRdata_i[{lane, 3'b000} +: 8];

    assign memEn_o    = (ex_i.memOp != memNone);
    assign memAddr_o  = ex_i.aluOut;
    assign memWen_o   = (ex_i.memOp == memStoreWord) ? 4'b1111 :
                        (ex_i.memOp == memStoreByte) ? (4'b0001 << lane) : 4'b0000;
    assign memWdata_o = (ex_i.memOp == memStoreByte) ? {4{ex_i.storeVal[7:0]}}
                                                     : ex_i.storeVal;  // byte on every lane

    always_comb begin
        case (ex_i.memOp)
            memLoadByte:  loadVal = {{24{loadByte[7]}}, loadByte};
            memLoadByteU: loadVal = {24'h000000, loadByte};
            default:      loadVal = memRdata_i;
        endcase
    end

    assign result_o = isLoad ? loadVal : ex_i.aluOut;  // feeds forwarding too

    assign wbDebug_o = '{
        valid:   ex_i.valid & ~dataStall_i,
        pc:      ex_i.pc,
        regWen:  ex_i.regWrite & (ex_i.destIdx != '0) & ~dataStall_i,
        regNum:  ex_i.destIdx,
        regData: result_o
    };

    wenOnlyStore: assert property (@(posedge clk) disable iff (!rstN_i)
        (memWen_o != 4'b0000) |-> isStore)
        else $error("byte enables set without a store");

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; #(
    parameter wordT resetPc = RESET_PC
) (
    input  wire        clk,
    input  wire        rstN_i,
    output wordT       instAddr_o,
    output logic       instEn_o,
    input  wire wordT  instr_i,
    output logic       memEn_o,
    output wordT       memAddr_o,
    output logic [3:0] memWen_o,
    output wordT       memWdata_o,
    input  wire wordT  memRdata_i,
    input  wire        dataStall_i,
    output wbDebugT    wbDebug_o
);

    logic       stall;
    logic       flushFd;
    logic       branchTaken;
    wordT       branchTarget;
    wordT       pcF;
    fdT         fdD, fdQ;
    ctrlT       ctrlD;
    wordT       immD;
    logic [4:0] shamtD;
    wordT       rsValD, rtValD;
    decExT      deD, deQ;
    exMemT      exD, exQ;
    memWbT      mwD, mwQ;
    wordT       memResult;
    fwdSelT     fwdA, fwdB;

    assign fdD = '{valid: 1'b1, pc: pcF, instr: instr_i};
    assign deD = '{pc: fdQ.pc, rsVal: rsValD, rtVal: rtValD, rsIdx: fdQ.instr[25:21],
                   rtIdx: fdQ.instr[20:16], imm: immD, shamt: shamtD, ctrl: ctrlD};
    assign mwD = '{destIdx: exQ.destIdx, result: memResult, regWrite: exQ.regWrite};

    fetchUnit #(.resetPc(resetPc)) fetch_i (.clk, .rstN_i, .stall_i(stall),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget), .pc_o(pcF),
        .instAddr_o, .instEn_o);

    pipeReg #(.payloadT(fdT)) fdReg_i (.clk, .rstN_i, .stall_i(stall), .flush_i(flushFd),
        .d_i(fdD), .q_o(fdQ));

    instrDecoder decode_i (.valid_i(fdQ.valid), .instr_i(fdQ.instr), .ctrl_o(ctrlD),
        .imm_o(immD), .shamt_o(shamtD));

    regFile regs_i (.clk, .rstN_i, .we_i(mwQ.regWrite & ~stall), .waddr_i(mwQ.destIdx),
        .wdata_i(mwQ.result), .raddrA_i(fdQ.instr[25:21]), .raddrB_i(fdQ.instr[20:16]),
        .rdataA_o(rsValD), .rdataB_o(rtValD));

    pipeReg #(.payloadT(decExT)) deReg_i (.clk, .rstN_i, .stall_i(stall), .flush_i(1'b0),
        .d_i(deD), .q_o(deQ));

    executeStage execute_i (.de_i(deQ), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memResult_i(memResult), .wbResult_i(mwQ.result), .exOut_o(exD),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget));

    hazardUnit hazard_i (.clk, .rstN_i, .exRsIdx_i(deQ.rsIdx), .exRtIdx_i(deQ.rtIdx),
        .memDest_i(exQ.destIdx), .memRegWrite_i(exQ.regWrite), .wbDest_i(mwQ.destIdx),
        .wbRegWrite_i(mwQ.regWrite), .branchTaken_i(branchTaken), .dataStall_i,
        .stall_o(stall), .flushFd_o(flushFd), .fwdA_o(fwdA), .fwdB_o(fwdB));

    pipeReg #(.payloadT(exMemT)) emReg_i (.clk, .rstN_i, .stall_i(stall), .flush_i(1'b0),
        .d_i(exD), .q_o(exQ));

    memAccess memory_i (.clk, .rstN_i, .ex_i(exQ), .memRdata_i, .dataStall_i, .memEn_o,
        .memAddr_o, .memWen_o, .memWdata_o, .result_o(memResult), .wbDebug_o);

    pipeReg #(.payloadT(memWbT)) mwReg_i (.clk, .rstN_i, .stall_i(stall), .flush_i(1'b0),
        .d_i(mwD), .q_o(mwQ));

endmodule

`default_nettype wire

/* verif/wbChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module wbChecker import mipsPkg::*; #(
    parameter int   progLen = 200,
    parameter wordT basePc  = RESET_PC
) (
    input  wire          clk,
    input  wire          rstN_i,
    input  wire wordT    prog_i [progLen],
    input  wire wbDebugT wbDebug_i,
    input  wire          memEn_i,
    input  wire [3:0]    memWen_i,
    input  wire wordT    memAddr_i,
    input  wire wordT    memWdata_i,
    input  wire          dataStall_i,
    input  wire          instEn_i,
    output logic         done_o,
    output int           valueErrs_o,
    output int           otherErrs_o
);

    localparam wordT lastPc = basePc + 32'(4 * (progLen - 1));

    wordT       modelRegs [32];
    wordT       modelMem [wordT];
    wordT       modelPc;
    wordT       modelNpc;
    logic       expStore;
    logic       expMem;
    logic [3:0] expWen;
    wordT       expAddr;
    wordT       expData;
    wbDebugT    expRet;
    logic       done      = 1'b0;
    int         valueErrs = 0;
    int         otherErrs = 0;

    assign done_o      = done;
    assign valueErrs_o = valueErrs;
    assign otherErrs_o = otherErrs;

    function automatic wordT fillWord(wordT wordAddr);
        return (wordAddr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    // one instruction of the ISA model, pc and npc carry the delay slot
    function automatic wbDebugT stepModel();
        wordT       ins, rs, rt, simm, addr, wordAddr, word, res, npcNext, romOff;
        logic [7:0] byteVal;
        regIdxT     dest;
        logic       wr;
        wbDebugT    ret;
        romOff   = (modelPc - basePc) >> 2;
        ins      = (romOff < progLen) ? prog_i[romOff] : '0;
        rs       = modelRegs[ins[25:21]];
        rt       = modelRegs[ins[20:16]];
        simm     = {{16{ins[15]}}, ins[15:0]};
        addr     = rs + simm;
        wordAddr = {addr[31:2], 2'b00};
        word     = modelMem.exists(wordAddr) ? modelMem[wordAddr] : fillWord(wordAddr);
        byteVal  = word[{addr[1:0], 3'b000} +: 8];
        dest     = ins[20:16];
        wr       = 1'b1;
        res      = '0;
        npcNext  = modelNpc + 32'd4;
        expStore = 1'b0;
        expAddr  = addr;
        case (ins[31:26])
            opSpecial: begin
                dest = ins[15:11];
                case (ins[5:0])
                    fnSll:   res = rt << ins[10:6];
                    fnAddu:  res = rs + rt;
                    fnSubu:  res = rs - rt;
                    fnAnd:   res = rs & rt;
                    fnOr:    res = rs | rt;
                    fnXor:   res = rs ^ rt;
                    fnSlt:   res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            opAddiu: res = rs + simm;
            opAndi:  res = rs & {16'h0000, ins[15:0]};
            opOri:   res = rs | {16'h0000, ins[15:0]};
            opLui:   res = {ins[15:0], 16'h0000};
            opLw:    res = word;
            opLb:    res = {{24{byteVal[7]}}, byteVal};
            opLbu:   res = {24'h000000, byteVal};
            opSw, opSb: begin
                wr       = 1'b0;
                expStore = 1'b1;
                expWen   = (ins[31:26] == opSw) ? 4'b1111 : (4'b0001 << addr[1:0]);
                expData  = (ins[31:26] == opSw) ? rt : {4{rt[7:0]}};
                for (int b = 0; b < 4; b++) begin
                    if (expWen[b]) begin
                        word[b*8 +: 8] = expData[b*8 +: 8];
                    end
                end
                modelMem[wordAddr] = word;
            end
            opBeq, opBne: begin
                wr = 1'b0;
                if ((rs == rt) == (ins[31:26] == opBeq)) begin
                    npcNext = modelPc + 32'd4 + {simm[29:0], 2'b00};
                end
            end
            default: wr = 1'b0;
        endcase
        expMem = expStore || (ins[31:26] == opLw) || (ins[31:26] == opLb)
                 || (ins[31:26] == opLbu);  // loads and stores touch the data port
        if (wr && dest != '0) begin
            modelRegs[dest] = res;
        end
        ret = '{valid: 1'b1, pc: modelPc, regWen: wr && (dest != '0), regNum: dest,
                regData: res};
        modelPc  = modelNpc;
        modelNpc = npcNext;
        return ret;
    endfunction

    task automatic checkField(string name, wordT got, wordT exp);
        if (got !== exp) begin
            valueErrs++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!rstN_i) begin
            foreach (modelRegs[r]) begin
                modelRegs[r] = '0;
            end
            modelMem.delete();
            modelPc  = basePc;
            modelNpc = basePc + 32'd4;
        end else if (!done) begin
            if (!dataStall_i) begin
                checkField("instEn_o", 32'(instEn_i), 32'd1);  // fetch runs every free cycle
            end
            if ($isunknown(wbDebug_i.valid)) begin
                otherErrs++;
                $display("debug valid is unknown at %0t", $time);
            end else if (wbDebug_i.valid) begin
                expRet = stepModel();
                checkField("wbDebug_o.pc", wbDebug_i.pc, expRet.pc);
                checkField("wbDebug_o.regWen", 32'(wbDebug_i.regWen), 32'(expRet.regWen));
                if (expRet.regWen) begin
                    checkField("wbDebug_o.regNum", 32'(wbDebug_i.regNum), 32'(expRet.regNum));
                    checkField("wbDebug_o.regData", wbDebug_i.regData, expRet.regData);
                end
                checkField("memEn_o", 32'(memEn_i), 32'(expMem));
                if (expMem) begin
                    checkField("memAddr_o", memAddr_i, expAddr);
                end
                if (expStore) begin
                    checkField("memWen_o", 32'(memWen_i), 32'(expWen));
                    checkField("memWdata_o", memWdata_i, expData);
                end else begin
                    checkField("memWen_o", 32'(memWen_i), 32'd0);
                end
                if (wbDebug_i.pc == lastPc) begin
                    done <= 1'b1;  // last program instruction retired
                end
            end else if ((memEn_i || memWen_i != 4'b0000) && !dataStall_i) begin
                otherErrs++;
                $display("memory access at %0t with no instruction retiring", $time);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tbMips.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMips import mipsPkg::*; ();

    localparam int   progLen     = 200;
    localparam int   resetCycles = 10;
    localparam int   clkPeriod   = 4;
    localparam wordT lfsrTaps    = 32'h80200003;

    logic       clk;
    logic       rstN;
    logic       dataStall;
    wordT       instr    = '0;
    wordT       memRdata = '0;
    wordT       instAddr;
    wordT       memAddr;
    wordT       memWdata;
    logic       instEn;
    logic       memEn;
    logic [3:0] memWen;
    wbDebugT    wbDebug;
    logic       done;
    int         valueErrs;
    int         otherErrs;
    wordT       progRom [progLen];
    wordT       dataMem [wordT];
    int         memWrites = 0;
    int         stallLeft = 0;
    wordT       lfsr = 32'h9e8c87b4;
    wordT       romIdx;

    mipsCore #(.resetPc(RESET_PC)) dut_i (
        .clk, .rstN_i(rstN), .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memAddr_o(memAddr), .memWen_o(memWen), .memWdata_o(memWdata),
        .memRdata_i(memRdata), .dataStall_i(dataStall), .wbDebug_o(wbDebug)
    );

    wbChecker #(.progLen(progLen), .basePc(RESET_PC)) wbCheck_i (
        .clk, .rstN_i(rstN), .prog_i(progRom), .wbDebug_i(wbDebug), .memEn_i(memEn),
        .memWen_i(memWen), .memAddr_i(memAddr), .memWdata_i(memWdata),
        .dataStall_i(dataStall), .instEn_i(instEn), .done_o(done),
        .valueErrs_o(valueErrs), .otherErrs_o(otherErrs)
    );

    function automatic logic nextBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr   = (lfsr >> 1) ^ (outBit ? lfsrTaps : 32'h0);  // galois step
        return outBit;
    endfunction

    function automatic wordT randBits(int n);
        wordT val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val = {val[30:0], nextBit()};
        end
        return val;
    endfunction

    function automatic wordT fillWord(wordT wordAddr);
        return (wordAddr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic wordT readWord(wordT wordAddr);
        return dataMem.exists(wordAddr) ? dataMem[wordAddr] : fillWord(wordAddr);
    endfunction

    function automatic wordT randomInstr(int idx, logic inSlot);
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [7:0]  off;
        int          target;
        rs  = regIdxT'(randBits(3));
        rt  = regIdxT'(randBits(3));
        rd  = regIdxT'(randBits(3));
        sh  = 5'(randBits(5));
        imm = 16'(randBits(16));
        off = 8'(randBits(8));
        if (!inSlot && idx <= progLen - 3 && randBits(3) == 0) begin
            if (randBits(1)) begin
                rt = rs;  // equal operands make beq taken
            end
            target = idx + 2 + int'(randBits(3));
            if (target > progLen - 1) begin
                target = progLen - 1;
            end
            imm = 16'(target - idx - 1);  // offset counts from the delay slot
            return {(randBits(1) ? opBne : opBeq), rs, rt, imm};
        end
        case (randBits(4))
            0:       return {opSpecial, rs, rt, rd, 5'd0, fnAddu};
            1:       return {opSpecial, rs, rt, rd, 5'd0, fnSubu};
            2:       return {opSpecial, rs, rt, rd, 5'd0, fnAnd};
            3:       return {opSpecial, rs, rt, rd, 5'd0, fnOr};
            4:       return {opSpecial, rs, rt, rd, 5'd0, fnXor};
            5:       return {opSpecial, rs, rt, rd, 5'd0, fnSlt};
            6:       return {opSpecial, 5'd0, rt, rd, sh, fnSll};
            7:       return {opAddiu, rs, rt, imm};
            8:       return {opAndi, rs, rt, imm};
            9:       return {opOri, rs, rt, imm};
            10:      return {opLui, 5'd0, rt, imm};
            11:      return {opLw, 5'd0, rt, 8'h00, off[7:2], 2'b00};
            12:      return {opLb, 5'd0, rt, 8'h00, off};
            13:      return {opLbu, 5'd0, rt, 8'h00, off};
            14:      return {opSw, 5'd0, rt, 8'h00, off[7:2], 2'b00};
            default: return {opSb, 5'd0, rt, 8'h00, off};
        endcase
    endfunction

    task automatic buildProgram();
        logic inSlot;
        for (int i = 0; i < progLen; i++) begin
            inSlot = 1'b0;
            if (i > 0) begin
                inSlot = (progRom[i-1][31:26] == opBeq) || (progRom[i-1][31:26] == opBne);
            end
            if (i < 7) begin
                progRom[i] = {opAddiu, 5'd0, 5'(i + 1), 16'(randBits(16))};  // seeds $1 to $7
            end else begin
                progRom[i] = randomInstr(i, inSlot);
            end
        end
    endtask

    task automatic storeBytes(wordT wordAddr, logic [3:0] wen, wordT data);
        wordT word;
        word = readWord(wordAddr);
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        dataMem[wordAddr] = word;
        memWrites++;  // wakes the read port
    endtask

    always @(instAddr) begin
        romIdx = (instAddr - RESET_PC) >> 2;
        if (!$isunknown(instAddr) && romIdx < progLen) begin
            instr = progRom[romIdx];
        end else begin
            instr = '0;  // nop past the end
        end
    end

    always @(memAddr or memWrites) begin
        if ($isunknown(memAddr)) begin
            memRdata = '0;
        end else begin
            memRdata = readWord({memAddr[31:2], 2'b00});
        end
    end

    always @(posedge clk) begin
        if (rstN && memEn && !dataStall && memWen != 4'b0000) begin
            storeBytes({memAddr[31:2], 2'b00}, memWen, memWdata);
        end
    end

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        rstN      = 1'b0;
        dataStall = 1'b0;
        buildProgram();
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
        while (!done) begin
            @(posedge clk);
            #1;
            if (stallLeft == 0 && !dataStall && randBits(2) == 0) begin
                stallLeft = 1 + int'(randBits(2) % 3);  // run of 1 to 3 cycles
            end
            dataStall = (stallLeft != 0);
            if (stallLeft != 0) begin
                stallLeft--;
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(clkPeriod * (20 * progLen + resetCycles));
        $display("watchdog expired before the last program instruction retired");
        $display("errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/mipsPkg.sv
logic/pipeReg.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/executeStage.sv
logic/hazardUnit.sv
logic/memAccess.sv
logic/mipsCore.sv
verif/wbChecker.sv
verif/tbMips.sv
